// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_ram
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
PASS_TEXT ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- "$(PASS_TEXT)" > /dev/null \
		&& echo "simulation passed" \
		|| { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
source/axi_ram_pkg.sv
source/ram_port_if.sv
source/fwft_fifo.sv
source/burst_addr_counter.sv
source/write_burst_fsm.sv
source/read_burst_fsm.sv
source/byte_ram.sv
source/axi_ram_top.sv
testbench/axi_ram_assert.sv
testbench/tb_axi_ram.sv

// ==== source/axi_ram_pkg.sv ====
package axi_ram_pkg;

  // bus geometry
  parameter int data_width = 32;
  parameter int addr_width = 12;             // byte address
  parameter int id_width   = 4;
  parameter int strb_width = data_width / 8;
  parameter int word_offset = $clog2(strb_width); // address bits below one word

  // defaults, overridden from the top level
  parameter int fifo_depth  = 16;
  parameter int ram_latency = 3;

  typedef logic [7:0] len_t;                 // beats minus one

  typedef enum logic [1:0] {
    wr_idle,
    wr_burst,
    wr_resp
  } write_state_e;

  typedef enum logic {
    rd_idle,
    rd_issue
  } read_state_e;

endpackage

// ==== source/axi_ram_top.sv ====
`timescale 1ns/1ps

module axi_ram_top import axi_ram_pkg::*; #(
  parameter int fifo_depth  = axi_ram_pkg::fifo_depth,
  parameter int ram_latency = axi_ram_pkg::ram_latency
) (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  input  logic [id_width-1:0]   s_axi_awid,
  input  logic [addr_width-1:0] s_axi_awaddr,
  input  len_t                  s_axi_awlen,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  input  logic [data_width-1:0] s_axi_wdata,
  input  logic [strb_width-1:0] s_axi_wstrb,
  input  logic                  s_axi_wlast,  // not checked, beat count comes from awlen
  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  output logic [id_width-1:0]   s_axi_bid,
  output logic [1:0]            s_axi_bresp,
  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,
  input  logic [id_width-1:0]   s_axi_arid,
  input  logic [addr_width-1:0] s_axi_araddr,
  input  len_t                  s_axi_arlen,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  output logic [id_width-1:0]   s_axi_rid,
  output logic [data_width-1:0] s_axi_rdata,
  output logic [1:0]            s_axi_rresp,
  output logic                  s_axi_rlast,
  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready
);

  localparam int cmd_width  = addr_width + $bits(len_t) + id_width;
  localparam int wdat_width = data_width + strb_width;
  localparam int ret_width  = data_width + id_width + 1;

  logic                  cmd_full, cmd_empty, cmd_pop;
  logic [cmd_width-1:0]  cmd_dout;
  logic                  wdat_full, wdat_empty, wdat_pop;
  logic [wdat_width-1:0] wdat_dout;
  logic                  ret_push, ret_last, ret_empty;
  logic [id_width-1:0]   ret_id;
  logic [ret_width-1:0]  ret_dout;
  logic [$clog2(fifo_depth+1)-1:0] ret_count;

  ram_port_if ram_if ();

  assign s_axi_awready = !cmd_full;
  assign s_axi_wready  = !wdat_full;
  assign s_axi_bresp   = 2'b00; // always OKAY
  assign s_axi_rresp   = 2'b00;
  assign s_axi_rvalid  = !ret_empty;
  assign {s_axi_rlast, s_axi_rid, s_axi_rdata} = ret_dout;

  fwft_fifo #(.width(cmd_width), .fifo_depth(fifo_depth)) u_cmd_fifo (
    .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
    .push (s_axi_awvalid && s_axi_awready), .din ({s_axi_awaddr, s_axi_awlen, s_axi_awid}),
    .pop (cmd_pop), .dout (cmd_dout), .full (cmd_full), .empty (cmd_empty), .count ()
  );

  fwft_fifo #(.width(wdat_width), .fifo_depth(fifo_depth)) u_wdat_fifo (
    .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
    .push (s_axi_wvalid && s_axi_wready), .din ({s_axi_wdata, s_axi_wstrb}),
    .pop (wdat_pop), .dout (wdat_dout), .full (wdat_full), .empty (wdat_empty), .count ()
  );

  // return queue, never overflows thanks to read credit
  fwft_fifo #(.width(ret_width), .fifo_depth(fifo_depth)) u_ret_fifo (
    .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
    .push (ret_push), .din ({ret_last, ret_id, ram_if.rd_data}),
    .pop (s_axi_rvalid && s_axi_rready), .dout (ret_dout), .full (),
    .empty (ret_empty), .count (ret_count)
  );

  write_burst_fsm u_wr_fsm (
    .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
    .cmd_empty (cmd_empty), .cmd_addr (cmd_dout[cmd_width-1 -: addr_width]),
    .cmd_len (cmd_dout[id_width +: $bits(len_t)]), .cmd_id (cmd_dout[id_width-1:0]),
    .cmd_pop (cmd_pop), .wdat_empty (wdat_empty),
    .wdat_data (wdat_dout[wdat_width-1 -: data_width]), .wdat_strb (wdat_dout[strb_width-1:0]),
    .wdat_pop (wdat_pop), .bid (s_axi_bid), .bvalid (s_axi_bvalid), .bready (s_axi_bready),
    .ram_wr (ram_if.wr_master)
  );

  read_burst_fsm #(.fifo_depth(fifo_depth), .ram_latency(ram_latency)) u_rd_fsm (
    .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
    .arid (s_axi_arid), .araddr (s_axi_araddr), .arlen (s_axi_arlen),
    .arvalid (s_axi_arvalid), .arready (s_axi_arready), .ret_count (ret_count),
    .ret_push (ret_push), .ret_id (ret_id), .ret_last (ret_last),
    .ram_rd (ram_if.rd_master)
  );

  byte_ram #(.ram_latency(ram_latency)) u_ram (
    .s_axi_aclk (s_axi_aclk),
    .ram        (ram_if.ram)
  );

endmodule

// ==== source/burst_addr_counter.sv ====
`timescale 1ns/1ps

module burst_addr_counter import axi_ram_pkg::*; (
  input  logic                            s_axi_aclk,
  input  logic                            s_axi_aresetn,
  input  logic                            load,
  input  logic [addr_width-1:0]           start_addr, // byte address
  input  len_t                            len,
  input  logic                            step,
  output logic [addr_width-1:word_offset] addr,       // word address
  output logic                            last
);

  localparam int waddr_width = addr_width - word_offset;

  len_t remain; // beats left after the current one

  assign last = (remain == '0);

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      addr   <= '0;
      remain <= '0;
    end
    else if (load)
    begin
      addr   <= start_addr[addr_width-1:word_offset]; // low bits dropped, word aligned
      remain <= len;
    end
    else if (step)
    begin
      // one word per beat, wraps at the top of the array
      addr <= addr + waddr_width'(1);
      if (!last)
        remain <= remain - len_t'(1);
    end
  end

endmodule

// ==== source/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram import axi_ram_pkg::*; #(
  parameter int ram_latency = axi_ram_pkg::ram_latency
) (
  input  logic     s_axi_aclk,
  ram_port_if.ram  ram
);

  localparam int words = 2 ** (addr_width - word_offset);

  logic [data_width-1:0] mem     [0:words-1];
  logic [data_width-1:0] rd_pipe [0:ram_latency-1];

  // byte lanes written only where strobed
  always_ff @(posedge s_axi_aclk)
  begin
    if (ram.wr_en)
      for (int b = 0; b < strb_width; b++)
        if (ram.wr_strb[b])
          mem[ram.wr_addr][b*8 +: 8] <= ram.wr_data[b*8 +: 8];
  end

  // read first, then ram_latency-1 more register stages
  always_ff @(posedge s_axi_aclk)
  begin
    if (ram.rd_en)
      rd_pipe[0] <= mem[ram.rd_addr];
    for (int i = 1; i < ram_latency; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

  assign ram.rd_data = rd_pipe[ram_latency-1];

endmodule

// ==== source/fwft_fifo.sv ====
`timescale 1ns/1ps

module fwft_fifo import axi_ram_pkg::*; #(
  parameter int width      = data_width,
  parameter int fifo_depth = axi_ram_pkg::fifo_depth
) (
  input  logic                              s_axi_aclk,
  input  logic                              s_axi_aresetn,
  input  logic                              push,
  input  logic [width-1:0]                  din,
  input  logic                              pop,
  output logic [width-1:0]                  dout,
  output logic                              full,
  output logic                              empty,
  output logic [$clog2(fifo_depth+1)-1:0]   count
);

  localparam int ptr_width = $clog2(fifo_depth);
  localparam int cnt_width = $clog2(fifo_depth + 1);

  logic [width-1:0]     mem [0:fifo_depth-1];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = push && !full;   // pushes into a full fifo are dropped
  assign do_pop  = pop && !empty;

  assign full  = (count == cnt_width'(fifo_depth));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];       // head word always on the output

  always_ff @(posedge s_axi_aclk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + ptr_width'(1);
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + ptr_width'(1);
      case ({do_push, do_pop})
        2'b10:   count <= count + cnt_width'(1);
        2'b01:   count <= count - cnt_width'(1);
        default: count <= count; // both or neither, occupancy unchanged
      endcase
    end
  end

endmodule

// ==== source/ram_port_if.sv ====
`timescale 1ns/1ps

interface ram_port_if import axi_ram_pkg::*; ();

  // write port, driven by the write burst fsm
  logic                            wr_en;
  logic [addr_width-1:word_offset] wr_addr; // word address
  logic [data_width-1:0]           wr_data;
  logic [strb_width-1:0]           wr_strb;

  // read port, data comes back a fixed number of cycles later
  logic                            rd_en;
  logic [addr_width-1:word_offset] rd_addr;
  logic [data_width-1:0]           rd_data;

  modport wr_master (output wr_en, wr_addr, wr_data, wr_strb);
  modport rd_master (output rd_en, rd_addr, input rd_data);
  modport ram (input wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr, output rd_data);

endinterface

// ==== source/read_burst_fsm.sv ====
`timescale 1ns/1ps

module read_burst_fsm import axi_ram_pkg::*; #(
  parameter int fifo_depth  = axi_ram_pkg::fifo_depth,
  parameter int ram_latency = axi_ram_pkg::ram_latency
) (
  input  logic                                s_axi_aclk,
  input  logic                                s_axi_aresetn,
  input  logic [id_width-1:0]                 arid,
  input  logic [addr_width-1:0]               araddr,
  input  len_t                                arlen,
  input  logic                                arvalid,
  output logic                                arready,
  input  logic [$clog2(fifo_depth+1)-1:0]     ret_count,  // return fifo occupancy
  output logic                                ret_push,
  output logic [id_width-1:0]                 ret_id,
  output logic                                ret_last,
  ram_port_if.rd_master                       ram_rd
);

  localparam int cnt_width = $clog2(fifo_depth + ram_latency + 1);
  localparam int sum_width = cnt_width + 1;

  read_state_e           state;
  logic                  ar_hs;
  logic                  beat_last;
  logic [id_width-1:0]   rid_q;
  logic [cnt_width-1:0]  in_flight;
  logic [sum_width-1:0]  credit_sum;
  logic                  credit_ok;
  logic [ram_latency-1:0] stage_valid;
  logic [id_width-1:0]   stage_id   [0:ram_latency-1];
  logic                  stage_last [0:ram_latency-1];

  burst_addr_counter u_addr_cnt (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .load          (ar_hs),
    .start_addr    (araddr),
    .len           (arlen),
    .step          (ram_rd.rd_en),
    .addr          (ram_rd.rd_addr),
    .last          (beat_last)
  );

  assign arready = (state == rd_idle);
  assign ar_hs   = arvalid && arready;

  always_comb
  begin
    in_flight = '0;
    for (int i = 0; i < ram_latency; i++)
      in_flight = in_flight + cnt_width'(stage_valid[i]);
  end

  // queued plus in flight must leave room for one more beat
  assign credit_sum   = sum_width'(ret_count) + sum_width'(in_flight);
  assign credit_ok    = (credit_sum < sum_width'(fifo_depth));
  assign ram_rd.rd_en = (state == rd_issue) && credit_ok;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
      state <= rd_idle;
    else if (ar_hs)
      state <= rd_issue;
    else if (ram_rd.rd_en && beat_last)
      state <= rd_idle; // pipeline drains on its own
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (ar_hs)
      rid_q <= arid;
  end

  // valid/id/last travel beside the ram read latency
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
      stage_valid <= '0;
    else
      for (int i = 0; i < ram_latency; i++)
        stage_valid[i] <= (i == 0) ? ram_rd.rd_en : stage_valid[i-1];
  end

  always_ff @(posedge s_axi_aclk)
  begin
    stage_id[0]   <= rid_q;
    stage_last[0] <= beat_last;
    for (int i = 1; i < ram_latency; i++)
    begin
      stage_id[i]   <= stage_id[i-1];
      stage_last[i] <= stage_last[i-1];
    end
  end

  assign ret_push = stage_valid[ram_latency-1]; // lines up with ram rd_data
  assign ret_id   = stage_id[ram_latency-1];
  assign ret_last = stage_last[ram_latency-1];

endmodule

// ==== source/write_burst_fsm.sv ====
`timescale 1ns/1ps

module write_burst_fsm import axi_ram_pkg::*; (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  // write command queue
  input  logic                  cmd_empty,
  input  logic [addr_width-1:0] cmd_addr,
  input  len_t                  cmd_len,
  input  logic [id_width-1:0]   cmd_id,
  output logic                  cmd_pop,
  // write data queue
  input  logic                  wdat_empty,
  input  logic [data_width-1:0] wdat_data,
  input  logic [strb_width-1:0] wdat_strb,
  output logic                  wdat_pop,
  // write response
  output logic [id_width-1:0]   bid,
  output logic                  bvalid,
  input  logic                  bready,
  ram_port_if.wr_master         ram_wr
);

  write_state_e state;
  write_state_e state_nxt;
  logic         beat_last;
  logic         step;

  burst_addr_counter u_addr_cnt (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .load          (cmd_pop),
    .start_addr    (cmd_addr),
    .len           (cmd_len),
    .step          (step),
    .addr          (ram_wr.wr_addr),
    .last          (beat_last)
  );

  // a burst starts only once its first beat is queued
  assign cmd_pop  = (state == wr_idle) && !cmd_empty && !wdat_empty;
  assign wdat_pop = (state == wr_burst) && !wdat_empty;
  assign step     = wdat_pop;

  assign ram_wr.wr_en   = wdat_pop; // beat goes to the ram in the pop cycle
  assign ram_wr.wr_data = wdat_data;
  assign ram_wr.wr_strb = wdat_strb;

  assign bvalid = (state == wr_resp);

  always_comb
  begin
    state_nxt = state;
    case (state)
      wr_idle:  if (cmd_pop) state_nxt = wr_burst;
      wr_burst: if (wdat_pop && beat_last) state_nxt = wr_resp;
      wr_resp:  if (bready) state_nxt = wr_idle; // held until accepted
      default:  state_nxt = wr_idle;
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
      state <= wr_idle;
    else
      state <= state_nxt;
  end

  // id stays put through the whole burst and the response
  always_ff @(posedge s_axi_aclk)
  begin
    if (cmd_pop)
      bid <= cmd_id;
  end

endmodule

// ==== testbench/axi_ram_assert.sv ====
`timescale 1ns/1ps

module axi_ram_assert import axi_ram_pkg::*; (
  input logic                  s_axi_aclk,
  input logic                  s_axi_aresetn,
  input logic                  s_axi_bvalid,
  input logic                  s_axi_bready,
  input logic [id_width-1:0]   s_axi_bid,
  input logic                  s_axi_rvalid,
  input logic                  s_axi_rready,
  input logic [data_width-1:0] s_axi_rdata,
  input logic                  s_axi_rlast,
  input logic                  s_axi_arvalid,
  input len_t                  s_axi_arlen,
  input logic                  s_axi_arready,
  input logic                  rd_en
);

  logic [$bits(len_t):0] beats_left; // beats of the accepted read burst not yet sent to the ram

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
      beats_left <= '0;
    else if (s_axi_arvalid && s_axi_arready)
      beats_left <= {1'b0, s_axi_arlen} + 1'b1;
    else if (rd_en && beats_left != '0)
      beats_left <= beats_left - 1'b1;
  end

  // response held with a stable id until taken
  a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bid))
    else $error("bvalid or bid changed before bready");

  a_r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rlast))
    else $error("rvalid, rdata or rlast changed while rready was low");

  a_ar_busy: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    beats_left != '0 |-> !s_axi_arready)
    else $error("arready high while a read burst was issuing");

endmodule

bind axi_ram_top axi_ram_assert u_assert (
  .s_axi_aclk    (s_axi_aclk),
  .s_axi_aresetn (s_axi_aresetn),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready),
  .s_axi_bid     (s_axi_bid),
  .s_axi_rvalid  (s_axi_rvalid),
  .s_axi_rready  (s_axi_rready),
  .s_axi_rdata   (s_axi_rdata),
  .s_axi_rlast   (s_axi_rlast),
  .s_axi_arvalid (s_axi_arvalid),
  .s_axi_arlen   (s_axi_arlen),
  .s_axi_arready (s_axi_arready),
  .rd_en         (ram_if.rd_en)
);

// ==== testbench/axi_ram_golden.txt ====
# command line: kind (w or r), id, byte address, len, strobe mask, all hex
# then len+1 lines of hex data, write data for w and expected read data for r
w 1 010 0 f
11223344
r 2 010 0 f
11223344
w 3 100 7 f
a0000000
a0000001
a0000002
a0000003
a0000004
a0000005
a0000006
a0000007
r 4 100 7 f
a0000000
a0000001
a0000002
a0000003
a0000004
a0000005
a0000006
a0000007
w 5 108 1 5
55555555
66666666
r 6 104 3 f
a0000001
a0550055
a0660066
a0000004

// ==== testbench/tb_axi_ram.sv ====
`timescale 1ns/1ps

module tb_axi_ram import axi_ram_pkg::*; ();

  localparam int    clk_period  = 8;
  localparam int    lat         = 3; // ram read latency handed to the dut
  localparam string vector_file = "testbench/axi_ram_golden.txt";
  localparam logic [1:0] resp_okay = 2'b00; // axi okay response

  logic                  s_axi_aclk = 1'b0;
  logic                  s_axi_aresetn;
  logic [id_width-1:0]   s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
  logic [addr_width-1:0] s_axi_awaddr, s_axi_araddr;
  len_t                  s_axi_awlen, s_axi_arlen;
  logic                  s_axi_awvalid, s_axi_awready, s_axi_arvalid, s_axi_arready;
  logic [data_width-1:0] s_axi_wdata, s_axi_rdata;
  logic [strb_width-1:0] s_axi_wstrb;
  logic                  s_axi_wlast, s_axi_wvalid, s_axi_wready;
  logic [1:0]            s_axi_bresp, s_axi_rresp;
  logic                  s_axi_bvalid, s_axi_bready;
  logic                  s_axi_rlast, s_axi_rvalid, s_axi_rready;

  integer seed         = 32'hb1e7;
  int     errors       = 0;
  int     checks       = 0;
  int     limit_cycles = 0;
  string  phase        = "reset";

  // one entry per command, beat data kept flat in file order
  logic [7:0]            cmd_kind [$];
  logic [id_width-1:0]   cmd_id   [$];
  logic [addr_width-1:0] cmd_addr [$];
  len_t                  cmd_len  [$];
  logic [strb_width-1:0] cmd_strb [$];
  logic [data_width-1:0] beat_data [$];

  always #(clk_period / 2) s_axi_aclk = ~s_axi_aclk;

  axi_ram_top #(.ram_latency(lat)) dut_i (.*);

  task automatic compare_word(input string name, input logic [data_width-1:0] exp,
                              input logic [data_width-1:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic load_vectors();
    int                    fd;
    int                    n;
    string                 line;
    logic [31:0]           f_id, f_addr, f_len, f_strb;
    logic [data_width-1:0] f_data;
    fd = $fopen(vector_file, "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the vector file %s", vector_file);
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      if (line[0] == "w" || line[0] == "r")
      begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f_id, f_addr, f_len, f_strb);
        if (n != 4)
        begin
          errors++;
          $display("malformed command line in the vector file: %s", line);
          continue;
        end
        cmd_kind.push_back(line[0]);
        cmd_id.push_back(f_id[id_width-1:0]);
        cmd_addr.push_back(f_addr[addr_width-1:0]);
        cmd_len.push_back(f_len[7:0]);
        cmd_strb.push_back(f_strb[strb_width-1:0]);
      end
      else if ($sscanf(line, "%h", f_data) == 1)
        beat_data.push_back(f_data);
    end
    $fclose(fd);
  endtask

  task automatic send_write(input int c, input int base);
    @(posedge s_axi_aclk);
    phase = $sformatf("waiting for awready on command %0d", c);
    s_axi_awid    <= cmd_id[c];
    s_axi_awaddr  <= cmd_addr[c];
    s_axi_awlen   <= cmd_len[c];
    s_axi_awvalid <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_awready)
      @(negedge s_axi_aclk);
    @(posedge s_axi_aclk);
    s_axi_awvalid <= 1'b0;
    phase = $sformatf("waiting for wready on command %0d", c);
    for (int b = 0; b <= int'(cmd_len[c]); b++)
    begin
      s_axi_wdata  <= beat_data[base + b];
      s_axi_wstrb  <= cmd_strb[c];
      s_axi_wlast  <= (b == int'(cmd_len[c]));
      s_axi_wvalid <= 1'b1;
      @(negedge s_axi_aclk);
      while (!s_axi_wready)
        @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
    end
    s_axi_wvalid <= 1'b0;
    s_axi_wlast  <= 1'b0;
    phase = $sformatf("waiting for the write response of command %0d", c);
    s_axi_bready <= ($random(seed) & 1) != 0; // random stall spans
    @(negedge s_axi_aclk);
    while (!(s_axi_bvalid && s_axi_bready))
    begin
      @(posedge s_axi_aclk);
      s_axi_bready <= ($random(seed) & 1) != 0;
      @(negedge s_axi_aclk);
    end
    compare_word($sformatf("command %0d bid", c), data_width'(cmd_id[c]), data_width'(s_axi_bid));
    compare_word($sformatf("command %0d bresp", c), data_width'(resp_okay),
                 data_width'(s_axi_bresp));
    @(posedge s_axi_aclk);
    s_axi_bready <= 1'b0;
    @(negedge s_axi_aclk);
    assert (!s_axi_bvalid)
    else
    begin
      errors++;
      $display("write command %0d gave more than one response", c);
    end
  endtask

  task automatic send_read(input int c, input int base);
    @(posedge s_axi_aclk);
    phase = $sformatf("waiting for arready on command %0d", c);
    s_axi_arid    <= cmd_id[c];
    s_axi_araddr  <= cmd_addr[c];
    s_axi_arlen   <= cmd_len[c];
    s_axi_arvalid <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_arready)
      @(negedge s_axi_aclk);
    @(posedge s_axi_aclk);
    s_axi_arvalid <= 1'b0;
    for (int b = 0; b <= int'(cmd_len[c]); b++)
    begin
      phase = $sformatf("waiting for read beat %0d of command %0d", b, c);
      s_axi_rready <= ($random(seed) & 1) != 0;
      @(negedge s_axi_aclk);
      while (!(s_axi_rvalid && s_axi_rready))
      begin
        @(posedge s_axi_aclk);
        s_axi_rready <= ($random(seed) & 1) != 0;
        @(negedge s_axi_aclk);
      end
      compare_word($sformatf("command %0d beat %0d rdata", c, b), beat_data[base + b],
                   s_axi_rdata);
      compare_word($sformatf("command %0d beat %0d rid", c, b), data_width'(cmd_id[c]),
                   data_width'(s_axi_rid));
      compare_bit($sformatf("command %0d beat %0d rlast", c, b), b == int'(cmd_len[c]),
                  s_axi_rlast);
      compare_word($sformatf("command %0d beat %0d rresp", c, b), data_width'(resp_okay),
                   data_width'(s_axi_rresp));
      @(posedge s_axi_aclk);
    end
    s_axi_rready <= 1'b0;
    @(negedge s_axi_aclk);
    assert (!s_axi_rvalid)
    else
    begin
      errors++;
      $display("read command %0d returned more beats than its length", c);
    end
  endtask

  initial
  begin
    int total;
    int base;
    s_axi_aresetn <= 1'b0;
    s_axi_awid    <= '0;
    s_axi_awaddr  <= '0;
    s_axi_awlen   <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wlast   <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_arid    <= '0;
    s_axi_araddr  <= '0;
    s_axi_arlen   <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;
    load_vectors();
    total = 0;
    foreach (cmd_len[c])
      total += int'(cmd_len[c]) + 1;
    if (total != beat_data.size() || total == 0)
    begin
      errors++;
      $display("vector file holds %0d data lines but its commands need %0d",
               beat_data.size(), total);
    end
    limit_cycles = (total + 20) * (lat + 40);
    repeat (4) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    @(negedge s_axi_aclk);
    compare_bit("reset bvalid", 1'b0, s_axi_bvalid);
    compare_bit("reset rvalid", 1'b0, s_axi_rvalid);
    compare_bit("reset awready", 1'b1, s_axi_awready);
    compare_bit("reset wready", 1'b1, s_axi_wready);
    compare_bit("reset arready", 1'b1, s_axi_arready);
    base = 0;
    if (total == beat_data.size())
      foreach (cmd_kind[c])
      begin
        if (cmd_kind[c] == "w")
          send_write(c, base);
        else
          send_read(c, base);
        base += int'(cmd_len[c]) + 1;
      end
    repeat (5) @(posedge s_axi_aclk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // watchdog, budget grows with the number of beats
  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge s_axi_aclk);
    $display("timeout, the dut stopped responding while %s", phase);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
